// File: include/proc_config.svh
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// ------------------------------
// Core widths
// ------------------------------
`define PROC_XLEN   32  // Data and address width
`define PROC_REG_AW 5   // Register index width, 32 registers

// First fetch address out of reset
`define PROC_RESET_PC 32'd0

// All-zero word decodes as add $0,$0,$0
// Every pipeline register holds this as its bubble
`define PROC_NOP 32'h0000_0000

`endif

// File: list.f
+incdir+include
rtl/proc_pkg.sv
rtl/alu.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/processor.sv
tests/clock_gen.sv
tests/tb_processor.sv

// File: rtl/alu.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module alu (
    input  logic [`PROC_XLEN-1:0]   operand_a,
    input  logic [`PROC_XLEN-1:0]   operand_b,
    input  proc_pkg::alu_op_e       alu_op,
    input  logic [`PROC_REG_AW-1:0] shamt,
    output logic [`PROC_XLEN-1:0]   result,
    output logic                    not_equal,
    output logic                    less_than   // Signed a < b
);

    localparam int MSB = `PROC_XLEN - 1;

    logic [`PROC_XLEN-1:0] diff;

    assign diff = operand_a - operand_b;   // Shared by sub and the compares

    always_comb begin
        case (alu_op)
            proc_pkg::ALU_ADD: result = operand_a + operand_b;
            proc_pkg::ALU_SUB: result = diff;
            proc_pkg::ALU_AND: result = operand_a & operand_b;
            proc_pkg::ALU_OR:  result = operand_a | operand_b;
            proc_pkg::ALU_SLL: result = operand_a << shamt;
            proc_pkg::ALU_SRA: result = $signed(operand_a) >>> shamt;
            default:           result = '0;   // Unsupported function writes zero
        endcase
    end

    assign not_equal = |diff;

    // Signs differ: a is less when negative. Same sign: difference cannot overflow
    assign less_than = (operand_a[MSB] != operand_b[MSB]) ? operand_a[MSB] : diff[MSB];

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module decode_stage (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic [`PROC_XLEN-1:0]   ir_fd,
    input  logic [`PROC_XLEN-1:0]   pc_fd,
    input  logic                    stall,
    input  logic                    flush,
    output logic [`PROC_REG_AW-1:0] ctrl_readRegA,
    output logic [`PROC_REG_AW-1:0] ctrl_readRegB,
    input  logic [`PROC_XLEN-1:0]   data_readRegA,
    input  logic [`PROC_XLEN-1:0]   data_readRegB,
    input  logic                    wb_byp_a,      // Writeback hits port A index
    input  logic                    wb_byp_b,
    input  logic [`PROC_XLEN-1:0]   data_writeReg,
    output proc_pkg::opcode_e       op_dx,
    output proc_pkg::alu_op_e       alu_op_dx,
    output logic [`PROC_REG_AW-1:0] rd_dx,
    output logic [`PROC_REG_AW-1:0] rs_dx,         // Index behind a_dx
    output logic [`PROC_REG_AW-1:0] rt_dx,         // Index behind b_dx
    output logic [`PROC_REG_AW-1:0] shamt_dx,
    output logic [`PROC_XLEN-1:0]   imm_dx,
    output logic [`PROC_XLEN-1:0]   a_dx,
    output logic [`PROC_XLEN-1:0]   b_dx,
    output logic [`PROC_XLEN-1:0]   pc_dx
);

    proc_pkg::opcode_e       op;
    proc_pkg::alu_op_e       alu_op;
    logic [`PROC_REG_AW-1:0] rd;
    logic [`PROC_REG_AW-1:0] rs;
    logic [`PROC_REG_AW-1:0] rt;
    logic                    is_branch;
    logic                    bubble;
    logic [`PROC_XLEN-1:0]   imm_ext;

    // ------------------------------
    // Field extraction and control
    // ------------------------------
    assign op = proc_pkg::opcode_e'(ir_fd[31:27]);
    assign rd = ir_fd[26:22];
    assign rs = ir_fd[21:17];
    assign rt = ir_fd[16:12];

    assign is_branch = (op == proc_pkg::OP_BNE) || (op == proc_pkg::OP_BLT);

    // aluop field only counts for R-type, everything else adds
    assign alu_op = (op == proc_pkg::OP_RTYPE) ? proc_pkg::alu_op_e'(ir_fd[6:2])
                                               : proc_pkg::ALU_ADD;

    // Branches compare $rd with $rs, sw stores $rd
    assign ctrl_readRegA = is_branch ? rd : rs;
    assign ctrl_readRegB = is_branch ? rs :
                           (op == proc_pkg::OP_SW) ? rd : rt;

    // Absolute target for j, signed 17-bit offset otherwise
    assign imm_ext = (op == proc_pkg::OP_J) ? {5'd0, ir_fd[26:0]}
                                            : {{15{ir_fd[16]}}, ir_fd[16:0]};

    assign bubble = stall || flush;   // Load-use hole or squashed path

    // ------------------------------
    // Decode/execute register
    // ------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n || bubble) begin
            op_dx     <= proc_pkg::OP_RTYPE;   // add $0,$0,$0
            alu_op_dx <= proc_pkg::ALU_ADD;
            rd_dx     <= '0;
            rs_dx     <= '0;                   // Register 0 never bypasses
            rt_dx     <= '0;
        end else begin
            op_dx     <= op;
            alu_op_dx <= alu_op;
            rd_dx     <= rd;
            rs_dx     <= ctrl_readRegA;
            rt_dx     <= ctrl_readRegB;
        end
    end

    // Payload, only meaningful behind a valid op
    always_ff @(posedge clock) begin
        shamt_dx <= ir_fd[11:7];
        imm_dx   <= imm_ext;
        a_dx     <= wb_byp_a ? data_writeReg : data_readRegA;  // Write-before-read
        b_dx     <= wb_byp_b ? data_writeReg : data_readRegB;
        pc_dx    <= pc_fd;
    end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module execute_stage (
    input  logic                    clock,
    input  logic                    rst_n,
    input  proc_pkg::opcode_e       op_dx,
    input  proc_pkg::alu_op_e       alu_op_dx,
    input  logic [`PROC_REG_AW-1:0] rd_dx,
    input  logic [`PROC_REG_AW-1:0] shamt_dx,
    input  logic [`PROC_XLEN-1:0]   imm_dx,
    input  logic [`PROC_XLEN-1:0]   a_dx,
    input  logic [`PROC_XLEN-1:0]   b_dx,
    input  logic [`PROC_XLEN-1:0]   pc_dx,          // PC+1 of this instruction
    input  proc_pkg::byp_sel_e      sel_a,
    input  proc_pkg::byp_sel_e      sel_b,
    output logic [`PROC_XLEN-1:0]   xm_result,
    input  logic [`PROC_XLEN-1:0]   data_writeReg,
    output logic                    redirect,
    output logic [`PROC_XLEN-1:0]   redirect_pc,
    output logic                    flush,
    output proc_pkg::opcode_e       op_xm,
    output logic [`PROC_REG_AW-1:0] rd_xm,
    output logic                    we_xm,
    output logic [`PROC_XLEN-1:0]   store_data_xm
);

    logic [`PROC_XLEN-1:0] opnd_a;
    logic [`PROC_XLEN-1:0] reg_b;    // Bypassed port B, also sw data
    logic [`PROC_XLEN-1:0] opnd_b;
    logic [`PROC_XLEN-1:0] alu_result;
    logic                  ne;
    logic                  lt;
    logic                  use_imm;
    logic                  writes;

    function automatic logic [`PROC_XLEN-1:0] bypass(input proc_pkg::byp_sel_e   sel,
                                                     input logic [`PROC_XLEN-1:0] reg_val,
                                                     input logic [`PROC_XLEN-1:0] mem_val,
                                                     input logic [`PROC_XLEN-1:0] wb_val);
        case (sel)
            proc_pkg::BYP_MEM: return mem_val;
            proc_pkg::BYP_WB:  return wb_val;
            default:           return reg_val;
        endcase
    endfunction

    // ------------------------------
    // Operands and ALU
    // ------------------------------
    assign opnd_a = bypass(sel_a, a_dx, xm_result, data_writeReg);
    assign reg_b  = bypass(sel_b, b_dx, xm_result, data_writeReg);

    assign use_imm = (op_dx == proc_pkg::OP_ADDI) || (op_dx == proc_pkg::OP_LW) ||
                     (op_dx == proc_pkg::OP_SW);
    assign opnd_b  = use_imm ? imm_dx : reg_b;   // Address or immediate add

    alu u_alu (
        .operand_a (opnd_a),
        .operand_b (opnd_b),
        .alu_op    (alu_op_dx),
        .shamt     (shamt_dx),
        .result    (alu_result),
        .not_equal (ne),
        .less_than (lt)
    );

    // ------------------------------
    // Branch and jump resolution
    // ------------------------------
    always_comb begin
        case (op_dx)
            proc_pkg::OP_BNE: redirect = ne;       // $rd != $rs
            proc_pkg::OP_BLT: redirect = lt;       // $rd < $rs signed
            proc_pkg::OP_J:   redirect = 1'b1;
            default:          redirect = 1'b0;     // Predicted not taken holds
        endcase
    end

    assign redirect_pc = (op_dx == proc_pkg::OP_J) ? imm_dx : pc_dx + imm_dx;
    assign flush       = redirect;                 // Kill the word now in decode

    assign writes = (op_dx == proc_pkg::OP_RTYPE) || (op_dx == proc_pkg::OP_ADDI) ||
                    (op_dx == proc_pkg::OP_LW);

    // Execute/memory register
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            op_xm <= proc_pkg::OP_RTYPE;
            rd_xm <= '0;
            we_xm <= 1'b0;
        end else begin
            op_xm <= op_dx;
            rd_xm <= rd_dx;
            we_xm <= writes;
        end
    end

    always_ff @(posedge clock) begin
        xm_result     <= alu_result;   // Also the dmem address for lw/sw
        store_data_xm <= reg_b;
    end

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module fetch_stage (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  stall,        // Load-use hold
    input  logic                  redirect,     // Taken branch or jump in execute
    input  logic [`PROC_XLEN-1:0] redirect_pc,
    output logic [`PROC_XLEN-1:0] address_imem,
    input  logic [`PROC_XLEN-1:0] q_imem,
    output logic [`PROC_XLEN-1:0] ir_fd,
    output logic [`PROC_XLEN-1:0] pc_fd         // PC+1 of the word in ir_fd
);

    logic [`PROC_XLEN-1:0] pc_q;
    logic [`PROC_XLEN-1:0] pc_plus1;

    assign address_imem = pc_q;                  // Memory answers in the same cycle
    assign pc_plus1     = pc_q + `PROC_XLEN'(1);  // Static not-taken

    // PC and fetched word
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc_q  <= `PROC_RESET_PC;
            ir_fd <= `PROC_NOP;
        end else if (redirect) begin             // Redirect beats a stall
            pc_q  <= redirect_pc;
            ir_fd <= `PROC_NOP;                  // Squash the wrong-path word
        end else if (!stall) begin
            pc_q  <= pc_plus1;
            ir_fd <= q_imem;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall)
            pc_fd <= pc_plus1;                   // Base for branch targets
    end

    // A load-use hold only ever freezes a real consumer word
    a_stall_real_word: assert property (@(posedge clock) disable iff (!rst_n)
        stall |-> (ir_fd != `PROC_NOP));

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module hazard_unit (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic [`PROC_REG_AW-1:0] ctrl_readRegA,    // Decode read indices
    input  logic [`PROC_REG_AW-1:0] ctrl_readRegB,
    input  logic [`PROC_REG_AW-1:0] rs_dx,            // Execute operand indices
    input  logic [`PROC_REG_AW-1:0] rt_dx,
    input  logic [`PROC_REG_AW-1:0] rd_dx,
    input  proc_pkg::opcode_e       op_dx,
    input  logic [`PROC_REG_AW-1:0] rd_xm,
    input  logic                    we_xm,
    input  logic [`PROC_REG_AW-1:0] ctrl_writeReg,    // Memory/writeback destination
    input  logic                    ctrl_writeEnable,
    output proc_pkg::byp_sel_e      sel_a,
    output proc_pkg::byp_sel_e      sel_b,
    output logic                    wb_byp_a,
    output logic                    wb_byp_b,
    output logic                    stall
);

    // Producer writes src, register 0 excluded
    function automatic logic hit(input logic                    we,
                                 input logic [`PROC_REG_AW-1:0] dst,
                                 input logic [`PROC_REG_AW-1:0] src);
        return we && (dst != '0) && (dst == src);
    endfunction

    // ------------------------------
    // Bypass selects
    // ------------------------------
    assign sel_a = hit(we_xm, rd_xm, rs_dx)                       ? proc_pkg::BYP_MEM :
                   hit(ctrl_writeEnable, ctrl_writeReg, rs_dx)    ? proc_pkg::BYP_WB  :
                                                                    proc_pkg::BYP_REG;
    assign sel_b = hit(we_xm, rd_xm, rt_dx)                       ? proc_pkg::BYP_MEM :
                   hit(ctrl_writeEnable, ctrl_writeReg, rt_dx)    ? proc_pkg::BYP_WB  :
                                                                    proc_pkg::BYP_REG;

    // Stand-in for the register file's write-before-read
    assign wb_byp_a = hit(ctrl_writeEnable, ctrl_writeReg, ctrl_readRegA);
    assign wb_byp_b = hit(ctrl_writeEnable, ctrl_writeReg, ctrl_readRegB);

    // Load data exists only from memory stage on, so one cycle hole
    assign stall = (op_dx == proc_pkg::OP_LW) &&
                   (hit(1'b1, rd_dx, ctrl_readRegA) || hit(1'b1, rd_dx, ctrl_readRegB));

    // Decode turns the stall into a bubble, so it can never repeat
    a_stall_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        stall |=> !stall);

endmodule

// File: rtl/mem_wb_stage.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module mem_wb_stage (
    input  logic                    clock,
    input  logic                    rst_n,
    input  proc_pkg::opcode_e       op_xm,
    input  logic [`PROC_REG_AW-1:0] rd_xm,
    input  logic                    we_xm,
    input  logic [`PROC_XLEN-1:0]   xm_result,
    input  logic [`PROC_XLEN-1:0]   store_data_xm,
    output logic [`PROC_XLEN-1:0]   address_dmem,
    output logic [`PROC_XLEN-1:0]   data,
    output logic                    wren,
    input  logic [`PROC_XLEN-1:0]   q_dmem,
    output logic                    ctrl_writeEnable,
    output logic [`PROC_REG_AW-1:0] ctrl_writeReg,
    output logic [`PROC_XLEN-1:0]   data_writeReg
);

    logic                  load_mw;       // Writeback takes memory data
    logic [`PROC_XLEN-1:0] result_mw;
    logic [`PROC_XLEN-1:0] load_data_mw;

    // Data memory straight from the execute/memory register
    assign address_dmem = xm_result;
    assign data         = store_data_xm;
    assign wren         = (op_xm == proc_pkg::OP_SW);

    // Memory/writeback register
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ctrl_writeEnable <= 1'b0;
            ctrl_writeReg    <= '0;
            load_mw          <= 1'b0;
        end else begin
            ctrl_writeEnable <= we_xm && (rd_xm != '0);   // $0 stays zero
            ctrl_writeReg    <= rd_xm;
            load_mw          <= (op_xm == proc_pkg::OP_LW);
        end
    end

    always_ff @(posedge clock) begin
        result_mw    <= xm_result;
        load_data_mw <= q_dmem;
    end

    assign data_writeReg = load_mw ? load_data_mw : result_mw;

    // A store moving on to writeback never writes the register file
    a_store_no_write: assert property (@(posedge clock) disable iff (!rst_n)
        wren |=> !ctrl_writeEnable);

endmodule

// File: rtl/proc_pkg.sv
package proc_pkg;

    // Instruction classes, bits [31:27] of the word
    typedef enum logic [4:0] {
        OP_RTYPE = 5'd0,  // Register-register ALU, function in aluop field
        OP_J     = 5'd1,  // Absolute jump to 27-bit target
        OP_BNE   = 5'd2,
        OP_ADDI  = 5'd5,
        OP_BLT   = 5'd6,
        OP_SW    = 5'd7,
        OP_LW    = 5'd8
    } opcode_e;

    // ALU functions, same codes as the R-type aluop field
    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5   // Arithmetic, sign fills from the left
    } alu_op_e;

    // Operand source for the execute bypass muxes
    typedef enum logic [1:0] {
        BYP_REG = 2'd0,  // Value latched in decode
        BYP_MEM = 2'd1,  // Execute/memory result
        BYP_WB  = 2'd2   // Writeback data
    } byp_sel_e;

endpackage

// File: rtl/processor.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module processor (
    input  logic                    clock,
    input  logic                    rst_n,
    // Instruction memory
    output logic [`PROC_XLEN-1:0]   address_imem,
    input  logic [`PROC_XLEN-1:0]   q_imem,
    // Data memory
    output logic [`PROC_XLEN-1:0]   address_dmem,
    output logic [`PROC_XLEN-1:0]   data,
    output logic                    wren,
    input  logic [`PROC_XLEN-1:0]   q_dmem,
    // Register file
    output logic                    ctrl_writeEnable,
    output logic [`PROC_REG_AW-1:0] ctrl_writeReg,
    output logic [`PROC_REG_AW-1:0] ctrl_readRegA,
    output logic [`PROC_REG_AW-1:0] ctrl_readRegB,
    output logic [`PROC_XLEN-1:0]   data_writeReg,
    input  logic [`PROC_XLEN-1:0]   data_readRegA,
    input  logic [`PROC_XLEN-1:0]   data_readRegB
);

    // ------------------------------
    // Stage-to-stage wires
    // ------------------------------
    logic                    stall;
    logic                    redirect;
    logic                    flush;
    logic [`PROC_XLEN-1:0]   redirect_pc;
    logic [`PROC_XLEN-1:0]   ir_fd;
    logic [`PROC_XLEN-1:0]   pc_fd;
    logic                    wb_byp_a;
    logic                    wb_byp_b;
    proc_pkg::opcode_e       op_dx;
    proc_pkg::alu_op_e       alu_op_dx;
    logic [`PROC_REG_AW-1:0] rd_dx;
    logic [`PROC_REG_AW-1:0] rs_dx;
    logic [`PROC_REG_AW-1:0] rt_dx;
    logic [`PROC_REG_AW-1:0] shamt_dx;
    logic [`PROC_XLEN-1:0]   imm_dx;
    logic [`PROC_XLEN-1:0]   a_dx;
    logic [`PROC_XLEN-1:0]   b_dx;
    logic [`PROC_XLEN-1:0]   pc_dx;
    proc_pkg::byp_sel_e      sel_a;
    proc_pkg::byp_sel_e      sel_b;
    logic [`PROC_XLEN-1:0]   xm_result;
    proc_pkg::opcode_e       op_xm;
    logic [`PROC_REG_AW-1:0] rd_xm;
    logic                    we_xm;
    logic [`PROC_XLEN-1:0]   store_data_xm;

    // Port names match the wires above throughout
    fetch_stage   u_fetch   (.*);   // PC, imem address, FD register
    decode_stage  u_decode  (.*);   // Regfile reads, DX register
    hazard_unit   u_hazard  (.*);   // Bypass selects, load-use stall
    execute_stage u_execute (.*);   // ALU, branch resolution, XM register
    mem_wb_stage  u_mem_wb  (.*);   // Dmem drive, MW register, writeback

endmodule

// File: run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_processor -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

// File: tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic rst_n     // Power-on reset, low for two cycles
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;   // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock) rst_n = 1'b1;  // Release on the falling edge
    end

endmodule

// File: tests/tb_processor.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module tb_processor;

    // ISA opcodes and R-type functions of the instruction format
    localparam logic [4:0] OPC_R = 5'd0, OPC_J = 5'd1, OPC_BNE = 5'd2, OPC_ADDI = 5'd5;
    localparam logic [4:0] OPC_BLT = 5'd6, OPC_SW = 5'd7, OPC_LW = 5'd8;
    localparam logic [4:0] F_ADD = 5'd0, F_SUB = 5'd1, F_AND = 5'd2, F_OR = 5'd3;
    localparam logic [4:0] F_SLL = 5'd4, F_SRA = 5'd5;

    logic                    clock;
    logic                    por_n;
    logic                    run_n;          // Reset between programs
    logic                    rst_n;
    logic                    in_reset;       // Last rising edge saw rst_n low
    logic [`PROC_XLEN-1:0]   address_imem, q_imem;
    logic [`PROC_XLEN-1:0]   address_dmem, data, q_dmem;
    logic                    wren;
    logic                    ctrl_writeEnable;
    logic [`PROC_REG_AW-1:0] ctrl_writeReg, ctrl_readRegA, ctrl_readRegB;
    logic [`PROC_XLEN-1:0]   data_writeReg, data_readRegA, data_readRegB;

    logic [31:0] imem [256];
    logic [31:0] dmem [1024];
    logic [31:0] rf [32];
    logic [31:0] ref_reg [32];       // Architectural state of the reference
    logic [31:0] ref_mem [1024];
    logic [36:0] exp_wr [$];         // {index, value}
    logic [63:0] exp_st [$];         // {address, data}
    logic [31:0] rng;
    int          mismatches;
    int          other_errors;
    int          cycles;
    int          deadline;

    assign rst_n = por_n & run_n;

    clock_gen u_clock_gen (.clock(clock), .rst_n(por_n));

    processor DUT (.*);

    // ------------------------------
    // Memory and register-file models
    // ------------------------------
    function automatic logic [31:0] dmem_fill(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    function automatic logic [31:0] reg_fill(input int i);
        return (i == 0) ? 32'd0 : (32'(i) * 32'h0101_0101) + 32'h1234;
    endfunction

    assign q_imem        = imem[address_imem[7:0]];     // Combinational reads
    assign q_dmem        = dmem[address_dmem[9:0]];
    assign data_readRegA = rf[ctrl_readRegA];
    assign data_readRegB = rf[ctrl_readRegB];

    always @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 1024; i++) dmem[i] <= dmem_fill(32'(i));
            for (int i = 0; i < 32; i++) rf[i] <= reg_fill(i);
        end else begin
            if (wren)
                dmem[address_dmem[9:0]] <= data;
            if (ctrl_writeEnable && ctrl_writeReg != 5'd0)   // $0 is hardwired
                rf[ctrl_writeReg] <= data_writeReg;
        end
    end

    always @(posedge clock) in_reset <= !rst_n;

    // ------------------------------
    // Encoders and random numbers
    // ------------------------------
    function automatic logic [31:0] enc_r(input logic [4:0] fn, rd, rs, rt, sh);
        return {OPC_R, rd, rs, rt, sh, fn, 2'b00};
    endfunction

    function automatic logic [31:0] enc_i(input logic [4:0] op, rd, rs,
                                          input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [26:0] target);
        return {OPC_J, target};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Architectural model that runs to the first self-jump
    function automatic int ref_run();
        logic [31:0] pc, ins, a, b, imm, addr, res;
        logic [4:0]  op, rd, rs, rt;
        int          n;
        for (int i = 0; i < 1024; i++) ref_mem[i] = dmem_fill(32'(i));
        for (int i = 0; i < 32; i++) ref_reg[i] = reg_fill(i);
        pc = 32'd0;
        n  = 0;
        while (n < 4000) begin
            ins = imem[pc[7:0]];
            op  = ins[31:27];
            rd  = ins[26:22];
            rs  = ins[21:17];
            rt  = ins[16:12];
            imm = {{15{ins[16]}}, ins[16:0]};
            n++;
            if (op == OPC_J && {5'd0, ins[26:0]} == pc)
                return n;                                 // Program end
            a    = ref_reg[rs];
            addr = a + imm;                               // lw and sw address
            res  = 32'd0;
            case (op)
                OPC_R: begin
                    b = ref_reg[rt];
                    case (ins[6:2])
                        F_ADD: res = a + b;
                        F_SUB: res = a - b;
                        F_AND: res = a & b;
                        F_OR:  res = a | b;
                        F_SLL: res = a << ins[11:7];
                        F_SRA: res = $signed(a) >>> ins[11:7];
                        default: res = 32'd0;
                    endcase
                end
                OPC_ADDI: res = a + imm;
                OPC_LW:   res = ref_mem[addr[9:0]];
                default:  res = 32'd0;
            endcase
            if ((op == OPC_R || op == OPC_ADDI || op == OPC_LW) && rd != 5'd0) begin
                ref_reg[rd] = res;
                exp_wr.push_back({rd, res});
            end
            if (op == OPC_SW) begin
                ref_mem[addr[9:0]] = ref_reg[rd];
                exp_st.push_back({addr, ref_reg[rd]});
            end
            // Branches compare $rd with $rs
            if (op == OPC_J)
                pc = {5'd0, ins[26:0]};
            else if (op == OPC_BNE && ref_reg[rd] != a)
                pc = pc + 32'd1 + imm;
            else if (op == OPC_BLT && $signed(ref_reg[rd]) < $signed(a))
                pc = pc + 32'd1 + imm;
            else
                pc = pc + 32'd1;
        end
        return -1;                                        // Never reached a self-jump
    endfunction

    // ------------------------------
    // Checking
    // ------------------------------
    task automatic check_value(input string name, input logic [63:0] got, exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    always @(negedge clock) begin
        logic [36:0] ew;
        logic [63:0] es;
        if (in_reset) begin
            if (ctrl_writeEnable !== 1'b0 || wren !== 1'b0) begin
                other_errors++;
                $display("write strobe high while the core is in reset");
            end
        end else begin
            if ($isunknown({ctrl_writeEnable, wren})) begin
                other_errors++;
                $display("write strobe is unknown after reset");
            end
            if (ctrl_writeEnable === 1'b1) begin
                if (exp_wr.size() == 0) begin
                    other_errors++;
                    $display("register write that is not on the reference path");
                end else begin
                    ew = exp_wr.pop_front();
                    check_value("ctrl_writeReg", 64'(ctrl_writeReg), 64'(ew[36:32]));
                    check_value("data_writeReg", 64'(data_writeReg), 64'(ew[31:0]));
                end
            end
            if (wren === 1'b1) begin
                if (exp_st.size() == 0) begin
                    other_errors++;
                    $display("store that is not on the reference path");
                end else begin
                    es = exp_st.pop_front();
                    check_value("address_dmem", 64'(address_dmem), 64'(es[63:32]));
                    check_value("data", 64'(data), 64'(es[31:0]));
                end
            end
        end
    end

    // Watchdog with a deadline that moves forward for each program
    always @(posedge clock) begin
        cycles++;
        if (cycles > deadline) begin
            $display("timeout: the core did not finish its program in time");
            $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic run_program(input string label);
        int n;
        @(negedge clock) run_n = 1'b0;                    // Hold reset while loading
        exp_wr.delete();
        exp_st.delete();
        n = ref_run();
        if (n < 0) begin
            other_errors++;
            $display("program %s has no reachable self-jump", label);
        end else begin
            deadline = cycles + 20 * n + 100;
            repeat (2) @(negedge clock);
            run_n = 1'b1;
            while (exp_wr.size() != 0 || exp_st.size() != 0)
                @(negedge clock);
            repeat (10) @(negedge clock);                 // Catch extra writes
        end
        run_n = 1'b0;                                     // Core parked before reload
    endtask

    task automatic build_random_program();
        logic [31:0] r;
        for (int i = 0; i < 256; i++) imem[i] = `PROC_NOP;
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            case (r[31:30])
                2'd0: imem[i] = enc_r(5'(r[29:20] % 6), {2'b0, r[2:0]}, {2'b0, r[5:3]},
                                      {2'b0, r[8:6]}, r[13:9]);
                2'd1: imem[i] = enc_i(OPC_ADDI, {2'b0, r[2:0]}, {2'b0, r[5:3]},
                                      {{9{r[16]}}, r[16:9]});
                2'd2: imem[i] = enc_i(OPC_LW, {2'b0, r[2:0]}, {2'b0, r[5:3]},
                                      {11'd0, r[14:9]});
                default: imem[i] = enc_i(OPC_SW, {2'b0, r[2:0]}, {2'b0, r[5:3]},
                                         {11'd0, r[14:9]});
            endcase
        end
        imem[40] = enc_j(27'd40);
    endtask

    initial begin
        run_n        = 1'b0;
        mismatches   = 0;
        other_errors = 0;
        cycles       = 0;
        deadline     = 1000;
        rng          = 32'hd6df;
        for (int i = 0; i < 1024; i++) dmem[i] <= dmem_fill(32'(i));
        for (int i = 0; i < 32; i++) rf[i] <= reg_fill(i);
        for (int i = 0; i < 256; i++) imem[i] = `PROC_NOP;

        // ALU chains, bypasses, $0, load-use and stores
        imem[0]  = enc_i(OPC_ADDI, 5'd1, 5'd0, 17'd10);
        imem[1]  = enc_i(OPC_ADDI, 5'd2, 5'd1, 17'd3);     // Memory bypass
        imem[2]  = enc_r(F_ADD, 5'd3, 5'd1, 5'd2, 5'd0);   // Writeback bypass
        imem[3]  = enc_r(F_SUB, 5'd4, 5'd3, 5'd1, 5'd0);
        imem[4]  = enc_r(F_AND, 5'd5, 5'd4, 5'd2, 5'd0);   // Decode bypass on $2
        imem[5]  = enc_r(F_OR,  5'd6, 5'd5, 5'd3, 5'd0);
        imem[6]  = enc_r(F_SLL, 5'd7, 5'd6, 5'd0, 5'd4);
        imem[7]  = enc_i(OPC_ADDI, 5'd9, 5'd0, -17'sd64);
        imem[8]  = enc_r(F_SRA, 5'd8, 5'd9, 5'd0, 5'd3);
        imem[9]  = enc_i(OPC_SW, 5'd8, 5'd0, 17'd8);       // Just computed
        imem[10] = enc_i(OPC_ADDI, 5'd0, 5'd1, 17'd7);     // Dropped write
        imem[11] = enc_r(F_ADD, 5'd10, 5'd0, 5'd1, 5'd0);
        imem[12] = enc_i(OPC_LW, 5'd11, 5'd0, 17'd8);
        imem[13] = enc_r(F_ADD, 5'd12, 5'd11, 5'd1, 5'd0); // Load-use
        imem[14] = enc_i(OPC_LW, 5'd13, 5'd0, 17'd100);
        imem[15] = enc_i(OPC_SW, 5'd13, 5'd0, 17'd101);    // Just loaded
        imem[16] = enc_j(27'd16);
        run_program("alu_chain");

        // Taken and not-taken branches whose wrong-path writes must vanish
        for (int i = 0; i < 256; i++) imem[i] = `PROC_NOP;
        imem[0]  = enc_i(OPC_ADDI, 5'd1, 5'd0, 17'd5);
        imem[1]  = enc_i(OPC_ADDI, 5'd2, 5'd0, 17'd5);
        imem[2]  = enc_i(OPC_BNE, 5'd1, 5'd2, 17'd2);      // Not taken
        imem[3]  = enc_i(OPC_ADDI, 5'd3, 5'd0, 17'd1);
        imem[4]  = enc_i(OPC_BNE, 5'd1, 5'd3, 17'd1);      // Taken
        imem[5]  = enc_i(OPC_ADDI, 5'd4, 5'd0, 17'd99);
        imem[6]  = enc_i(OPC_ADDI, 5'd5, 5'd0, -17'sd3);
        imem[7]  = enc_i(OPC_BLT, 5'd5, 5'd1, 17'd1);      // Taken on a signed compare
        imem[8]  = enc_i(OPC_ADDI, 5'd4, 5'd0, 17'd77);
        imem[9]  = enc_i(OPC_BLT, 5'd1, 5'd5, 17'd3);      // Not taken
        imem[10] = enc_j(27'd12);
        imem[11] = enc_i(OPC_SW, 5'd1, 5'd0, 17'd55);
        imem[12] = enc_i(OPC_SW, 5'd5, 5'd0, 17'd4);
        imem[13] = enc_j(27'd13);
        run_program("branches");

        for (int p = 0; p < 3; p++) begin
            build_random_program();
            run_program("random");
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
